// ==== periph_pkg.sv ====
`default_nettype none

package periph_pkg;

    typedef logic [31:0] word_t;       // bus address and data
    typedef logic [1:0]  htrans_t;
    typedef logic        hresp_t;      // okay / error only on ahb-lite
    typedef logic [7:0]  seg_t;        // active low, bit 7 is the dp
    typedef logic [3:0]  hex_digit_t;
    typedef logic [2:0]  digit_idx_t;
    typedef logic [11:0] ofs_t;        // offset inside a 4 KiB region
    typedef logic [15:0] led_t;
    typedef logic [15:0] sw_t;

    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;

    localparam hresp_t HRESP_OKAY  = 1'b0;
    localparam hresp_t HRESP_ERROR = 1'b1;

    localparam int   NUM_DIGITS = 6;
    localparam seg_t SEG_BLANK  = 8'hFF;

    // address map
    localparam word_t DTUBE_BASE  = 32'h4000_0000;
    localparam word_t GPIO_BASE   = 32'h4000_1000;
    localparam word_t REGION_MASK = 32'hFFFF_F000;

    localparam ofs_t DTUBE_HEX0_OFS = 12'h000;
    localparam ofs_t DTUBE_HEX1_OFS = 12'h004;
    localparam ofs_t DTUBE_HEX2_OFS = 12'h008;
    localparam ofs_t DTUBE_HEX3_OFS = 12'h00C;
    localparam ofs_t DTUBE_HEX4_OFS = 12'h010;
    localparam ofs_t DTUBE_HEX5_OFS = 12'h014;

    localparam ofs_t GPIO_LED_OFS = 12'h000;
    localparam ofs_t GPIO_SW_OFS  = 12'h004;

    // two-cycle error response of every slave
    typedef enum logic [1:0] {
        RESP_OK,
        RESP_ERR1,    // hready low, error
        RESP_ERR2     // hready high, error
    } resp_state_e;

    function automatic resp_state_e resp_next(input resp_state_e cur, input logic err_start);
        resp_state_e nxt;
        if (cur == RESP_ERR1) begin
            nxt = RESP_ERR2;
        end else if (err_start) begin
            nxt = RESP_ERR1;    // a new bad access may start in ERR2
        end else begin
            nxt = RESP_OK;
        end
        return nxt;
    endfunction

    function automatic logic resp_ready(input resp_state_e cur);
        return cur != RESP_ERR1;
    endfunction

    function automatic hresp_t resp_code(input resp_state_e cur);
        return (cur == RESP_OK) ? HRESP_OKAY : HRESP_ERROR;
    endfunction

endpackage

`default_nettype wire

// ==== ahb_periph_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahb_periph_mux (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire periph_pkg::word_t   haddr,
    input  wire periph_pkg::htrans_t htrans,
    input  wire                      hready_in,
    input  wire periph_pkg::word_t   hrdata_dtube,
    input  wire periph_pkg::word_t   hrdata_gpio,
    input  wire                      hready_dtube,
    input  wire                      hready_gpio,
    input  wire periph_pkg::hresp_t  hresp_dtube,
    input  wire periph_pkg::hresp_t  hresp_gpio,
    output logic                     hsel_dtube,
    output logic                     hsel_gpio,
    output periph_pkg::word_t        hrdata,
    output logic                     hready,
    output periph_pkg::hresp_t       hresp
);

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_DTUBE,
        OWN_GPIO,
        OWN_DEF      // unmapped, default slave answers
    } owner_e;

    periph_pkg::word_t       region;
    logic                    addr_valid;
    logic                    hit_none;
    owner_e                  owner;
    periph_pkg::resp_state_e def_state;

    assign region     = haddr & periph_pkg::REGION_MASK;
    assign hsel_dtube = (region == periph_pkg::DTUBE_BASE);
    assign hsel_gpio  = (region == periph_pkg::GPIO_BASE);
    assign hit_none   = !hsel_dtube && !hsel_gpio;
    assign addr_valid = hready_in && (htrans == periph_pkg::HTRANS_NONSEQ);

    // owner only moves on when the current data phase completes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner <= OWN_NONE;
        end else if (hready_in) begin
            if (!addr_valid) begin
                owner <= OWN_NONE;
            end else if (hsel_dtube) begin
                owner <= OWN_DTUBE;
            end else if (hsel_gpio) begin
                owner <= OWN_GPIO;
            end else begin
                owner <= OWN_DEF;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            def_state <= periph_pkg::RESP_OK;
        end else begin
            def_state <= periph_pkg::resp_next(def_state, addr_valid && hit_none);
        end
    end

    always_comb begin
        hrdata = '0;
        hready = 1'b1;
        hresp  = periph_pkg::HRESP_OKAY;
        case (owner)
            OWN_DTUBE: begin
                hrdata = hrdata_dtube;
                hready = hready_dtube;
                hresp  = hresp_dtube;
            end
            OWN_GPIO: begin
                hrdata = hrdata_gpio;
                hready = hready_gpio;
                hresp  = hresp_gpio;
            end
            OWN_DEF: begin
                hready = periph_pkg::resp_ready(def_state);
                hresp  = periph_pkg::resp_code(def_state);
            end
            default: ;    // idle bus
        endcase
    end

endmodule

`default_nettype wire

// ==== dtube_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dtube_ctrl (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      hsel,
    input  wire periph_pkg::word_t   haddr,
    input  wire periph_pkg::htrans_t htrans,
    input  wire                      hwrite,
    input  wire                      hready_in,
    input  wire periph_pkg::word_t   hwdata,
    output periph_pkg::word_t        hrdata,
    output logic                     hready,
    output periph_pkg::hresp_t       hresp,
    output periph_pkg::seg_t         hex0,
    output periph_pkg::seg_t         hex1,
    output periph_pkg::seg_t         hex2,
    output periph_pkg::seg_t         hex3,
    output periph_pkg::seg_t         hex4,
    output periph_pkg::seg_t         hex5
);

    periph_pkg::ofs_t                  ofs;
    logic                              acc;
    logic                              ofs_hit;
    periph_pkg::digit_idx_t            ofs_idx;
    logic                              wr_pend;
    periph_pkg::digit_idx_t            wr_idx;
    periph_pkg::hex_digit_t            digit [periph_pkg::NUM_DIGITS];
    logic [periph_pkg::NUM_DIGITS-1:0] written;   // digit blank until first write
    periph_pkg::hex_digit_t            rd_val;
    periph_pkg::seg_t                  seg [periph_pkg::NUM_DIGITS];
    periph_pkg::resp_state_e           state;

    function automatic periph_pkg::seg_t seg_encode(input periph_pkg::hex_digit_t d);
        case (d)
            4'h0: return 8'hC0;
            4'h1: return 8'hF9;
            4'h2: return 8'hA4;
            4'h3: return 8'hB0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hF8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'hA: return 8'h88;
            4'hB: return 8'h83;    // lower case b
            4'hC: return 8'hC6;
            4'hD: return 8'hA1;    // lower case d
            4'hE: return 8'h86;
            default: return 8'h8E;
        endcase
    endfunction

    assign ofs = haddr[11:0];
    assign acc = hsel && hready_in && (htrans == periph_pkg::HTRANS_NONSEQ);

    always_comb begin
        ofs_hit = 1'b1;
        ofs_idx = '0;
        case (ofs)
            periph_pkg::DTUBE_HEX0_OFS: ofs_idx = 3'd0;
            periph_pkg::DTUBE_HEX1_OFS: ofs_idx = 3'd1;
            periph_pkg::DTUBE_HEX2_OFS: ofs_idx = 3'd2;
            periph_pkg::DTUBE_HEX3_OFS: ofs_idx = 3'd3;
            periph_pkg::DTUBE_HEX4_OFS: ofs_idx = 3'd4;
            periph_pkg::DTUBE_HEX5_OFS: ofs_idx = 3'd5;
            default: ofs_hit = 1'b0;
        endcase
    end

    // address phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_pend <= 1'b0;
        end else begin
            wr_pend <= acc && hwrite && ofs_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (acc) begin
            wr_idx <= ofs_idx;
        end
    end

    // data phase write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            written <= '0;
            for (int i = 0; i < periph_pkg::NUM_DIGITS; i++) begin
                digit[i] <= '0;
            end
        end else if (wr_pend) begin
            digit[wr_idx]   <= hwdata[3:0];
            written[wr_idx] <= 1'b1;
        end
    end

    always_comb begin
        rd_val = digit[ofs_idx];
        if (wr_pend && (wr_idx == ofs_idx)) begin
            rd_val = hwdata[3:0];    // write still in its data phase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hrdata <= '0;
        end else if (acc && !hwrite && ofs_hit) begin
            hrdata <= periph_pkg::word_t'(rd_val);
        end else begin
            hrdata <= '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= periph_pkg::RESP_OK;
        end else begin
            state <= periph_pkg::resp_next(state, acc && !ofs_hit);
        end
    end

    assign hready = periph_pkg::resp_ready(state);
    assign hresp  = periph_pkg::resp_code(state);

    always_comb begin
        for (int i = 0; i < periph_pkg::NUM_DIGITS; i++) begin
            seg[i] = written[i] ? seg_encode(digit[i]) : periph_pkg::SEG_BLANK;
        end
    end

    assign hex0 = seg[0];
    assign hex1 = seg[1];
    assign hex2 = seg[2];
    assign hex3 = seg[3];
    assign hex4 = seg[4];
    assign hex5 = seg[5];

endmodule

`default_nettype wire

// ==== gpio_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_ctrl (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      hsel,
    input  wire periph_pkg::word_t   haddr,
    input  wire periph_pkg::htrans_t htrans,
    input  wire                      hwrite,
    input  wire                      hready_in,
    input  wire periph_pkg::word_t   hwdata,
    output periph_pkg::word_t        hrdata,
    output logic                     hready,
    output periph_pkg::hresp_t       hresp,
    input  wire periph_pkg::sw_t     sw,
    output periph_pkg::led_t         led
);

    periph_pkg::ofs_t        ofs;
    logic                    acc;
    logic                    led_hit;
    logic                    sw_hit;
    logic                    bad;
    logic                    wr_led;
    periph_pkg::led_t        led_fwd;
    periph_pkg::sw_t         sw_q1;
    periph_pkg::sw_t         sw_q2;
    periph_pkg::resp_state_e state;

    assign ofs     = haddr[11:0];
    assign acc     = hsel && hready_in && (htrans == periph_pkg::HTRANS_NONSEQ);
    assign led_hit = (ofs == periph_pkg::GPIO_LED_OFS);
    assign sw_hit  = (ofs == periph_pkg::GPIO_SW_OFS);
    assign bad     = !(led_hit || (sw_hit && !hwrite));    // sw is read only

    // switch synchronizer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sw_q1 <= '0;
            sw_q2 <= '0;
        end else begin
            sw_q1 <= sw;
            sw_q2 <= sw_q1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_led <= 1'b0;
        end else begin
            wr_led <= acc && hwrite && led_hit;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            led <= '0;
        end else if (wr_led) begin
            led <= hwdata[15:0];
        end
    end

    assign led_fwd = wr_led ? hwdata[15:0] : led;    // write-then-read bypass

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hrdata <= '0;
        end else if (acc && !hwrite && led_hit) begin
            hrdata <= periph_pkg::word_t'(led_fwd);
        end else if (acc && !hwrite && sw_hit) begin
            hrdata <= periph_pkg::word_t'(sw_q2);
        end else begin
            hrdata <= '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= periph_pkg::RESP_OK;
        end else begin
            state <= periph_pkg::resp_next(state, acc && bad);
        end
    end

    assign hready = periph_pkg::resp_ready(state);
    assign hresp  = periph_pkg::resp_code(state);

endmodule

`default_nettype wire

// ==== periph_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module periph_top (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire periph_pkg::word_t   haddr,
    input  wire periph_pkg::htrans_t htrans,
    input  wire                      hwrite,
    input  wire [2:0]                hsize,     // accepted, every access is a word
    input  wire periph_pkg::word_t   hwdata,
    input  wire periph_pkg::sw_t     sw,
    output wire periph_pkg::word_t   hrdata,
    output wire                      hready,
    output wire periph_pkg::hresp_t  hresp,
    output wire periph_pkg::seg_t    hex0,
    output wire periph_pkg::seg_t    hex1,
    output wire periph_pkg::seg_t    hex2,
    output wire periph_pkg::seg_t    hex3,
    output wire periph_pkg::seg_t    hex4,
    output wire periph_pkg::seg_t    hex5,
    output wire periph_pkg::led_t    led
);

    wire                     hsel_dtube;
    wire                     hsel_gpio;
    wire periph_pkg::word_t  hrdata_dtube;
    wire periph_pkg::word_t  hrdata_gpio;
    wire                     hready_dtube;
    wire                     hready_gpio;
    wire periph_pkg::hresp_t hresp_dtube;
    wire periph_pkg::hresp_t hresp_gpio;

    ahb_periph_mux mux_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .haddr        (haddr),
        .htrans       (htrans),
        .hready_in    (hready),
        .hrdata_dtube (hrdata_dtube),
        .hrdata_gpio  (hrdata_gpio),
        .hready_dtube (hready_dtube),
        .hready_gpio  (hready_gpio),
        .hresp_dtube  (hresp_dtube),
        .hresp_gpio   (hresp_gpio),
        .hsel_dtube   (hsel_dtube),
        .hsel_gpio    (hsel_gpio),
        .hrdata       (hrdata),
        .hready       (hready),
        .hresp        (hresp)
    );

    dtube_ctrl dtube_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .hsel      (hsel_dtube),
        .haddr     (haddr),
        .htrans    (htrans),
        .hwrite    (hwrite),
        .hready_in (hready),
        .hwdata    (hwdata),
        .hrdata    (hrdata_dtube),
        .hready    (hready_dtube),
        .hresp     (hresp_dtube),
        .hex0      (hex0),
        .hex1      (hex1),
        .hex2      (hex2),
        .hex3      (hex3),
        .hex4      (hex4),
        .hex5      (hex5)
    );

    gpio_ctrl gpio_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .hsel      (hsel_gpio),
        .haddr     (haddr),
        .htrans    (htrans),
        .hwrite    (hwrite),
        .hready_in (hready),
        .hwdata    (hwdata),
        .hrdata    (hrdata_gpio),
        .hready    (hready_gpio),
        .hresp     (hresp_gpio),
        .sw        (sw),
        .led       (led)
    );

endmodule

`default_nettype wire

// ==== tb_periph_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_periph_top;

    localparam int CLK_PERIOD      = 40;
    localparam int NUM_TESTS       = 5;
    localparam int WATCHDOG_CYCLES = 400 + 40 * NUM_TESTS;
    localparam int READY_LIMIT     = 16;

    // active low codes, indexed by digit value
    localparam periph_pkg::seg_t SEG_TABLE [16] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
        8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E
    };

    logic                   clk;
    logic                   rst_n;
    periph_pkg::word_t      haddr;
    periph_pkg::htrans_t    htrans;
    logic                   hwrite;
    logic [2:0]             hsize;
    periph_pkg::word_t      hwdata;
    periph_pkg::sw_t        sw;
    periph_pkg::word_t      hrdata;
    logic                   hready;
    periph_pkg::hresp_t     hresp;
    periph_pkg::seg_t       hex_out [periph_pkg::NUM_DIGITS];
    periph_pkg::led_t       led;

    periph_pkg::hex_digit_t exp_digit [periph_pkg::NUM_DIGITS];    // model of the display
    logic                   exp_written [periph_pkg::NUM_DIGITS];
    periph_pkg::led_t       exp_led;
    periph_pkg::word_t      lcg_state;
    int                     errors;
    int                     checks;

    periph_top dut_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .haddr  (haddr),
        .htrans (htrans),
        .hwrite (hwrite),
        .hsize  (hsize),
        .hwdata (hwdata),
        .sw     (sw),
        .hrdata (hrdata),
        .hready (hready),
        .hresp  (hresp),
        .hex0   (hex_out[0]),
        .hex1   (hex_out[1]),
        .hex2   (hex_out[2]),
        .hex3   (hex_out[3]),
        .hex4   (hex_out[4]),
        .hex5   (hex_out[5]),
        .led    (led)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("run timed out after %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    function automatic periph_pkg::word_t next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {lcg_state[15:0], lcg_state[31:16]};    // high bits are the better ones
    endfunction

    function automatic periph_pkg::word_t digit_addr(input int d);
        return periph_pkg::DTUBE_BASE + periph_pkg::word_t'(d * 4);
    endfunction

    task automatic check_word(input periph_pkg::word_t got, input periph_pkg::word_t exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL @%0t: %s got %08h expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_seg(input periph_pkg::seg_t got, input periph_pkg::seg_t exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL @%0t: %s got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_led(input periph_pkg::led_t got, input periph_pkg::led_t exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL @%0t: %s got %04h expected %04h", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(input periph_pkg::hresp_t got, input periph_pkg::hresp_t exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL @%0t: %s hresp %0b expected %0b", $time, what, got, exp);
        end
    endtask

    task automatic check_ready(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL @%0t: %s hready %0b expected %0b", $time, what, got, exp);
        end
    endtask

    task automatic check_display(input string what);
        for (int i = 0; i < periph_pkg::NUM_DIGITS; i++) begin
            check_seg(hex_out[i], exp_written[i] ? SEG_TABLE[exp_digit[i]] : 8'hFF,
                      $sformatf("%s hex%0d", what, i));
        end
    endtask

    task automatic wait_ready(input string what);
        int n;
        n = 0;
        while (hready !== 1'b1 && n < READY_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (hready !== 1'b1) begin
            errors++;
            $display("hready stayed low for %0d cycles during %s", READY_LIMIT, what);
        end
    endtask

    task automatic ahb_write(input periph_pkg::word_t addr, input periph_pkg::word_t data);
        @(negedge clk);
        haddr  = addr;
        htrans = periph_pkg::HTRANS_NONSEQ;
        hwrite = 1'b1;
        @(negedge clk);    // data phase
        htrans = periph_pkg::HTRANS_IDLE;
        hwdata = data;
        wait_ready($sformatf("write %08h", addr));
        check_resp(hresp, periph_pkg::HRESP_OKAY, $sformatf("write %08h", addr));
    endtask

    task automatic ahb_read(input periph_pkg::word_t addr, output periph_pkg::word_t data);
        @(negedge clk);
        haddr  = addr;
        htrans = periph_pkg::HTRANS_NONSEQ;
        hwrite = 1'b0;
        @(negedge clk);
        htrans = periph_pkg::HTRANS_IDLE;
        wait_ready($sformatf("read %08h", addr));
        check_resp(hresp, periph_pkg::HRESP_OKAY, $sformatf("read %08h", addr));
        data = hrdata;
    endtask

    // write data phase overlaps the read address phase
    task automatic write_then_read(input periph_pkg::word_t addr, input periph_pkg::word_t data,
                                   output periph_pkg::word_t rd);
        @(negedge clk);
        haddr  = addr;
        htrans = periph_pkg::HTRANS_NONSEQ;
        hwrite = 1'b1;
        @(negedge clk);
        hwdata = data;
        hwrite = 1'b0;
        check_ready(hready, 1'b1, "back to back write");
        @(negedge clk);
        htrans = periph_pkg::HTRANS_IDLE;
        wait_ready("back to back read");
        check_resp(hresp, periph_pkg::HRESP_OKAY, "back to back read");
        rd = hrdata;
    endtask

    task automatic ahb_expect_error(input periph_pkg::word_t addr, input logic write,
                                    input periph_pkg::word_t data, input string what);
        @(negedge clk);
        haddr  = addr;
        htrans = periph_pkg::HTRANS_NONSEQ;
        hwrite = write;
        @(negedge clk);
        htrans = periph_pkg::HTRANS_IDLE;    // idle while hready is low
        hwdata = data;
        check_ready(hready, 1'b0, {what, " first cycle"});
        check_resp(hresp, periph_pkg::HRESP_ERROR, {what, " first cycle"});
        @(negedge clk);
        check_ready(hready, 1'b1, {what, " second cycle"});
        check_resp(hresp, periph_pkg::HRESP_ERROR, {what, " second cycle"});
    endtask

    task automatic test_reset();
        check_display("after reset");
        check_ready(hready, 1'b1, "after reset");
        check_resp(hresp, periph_pkg::HRESP_OKAY, "after reset");
        check_word(hrdata, '0, "hrdata after reset");
        check_led(led, '0, "led after reset");
    endtask

    task automatic test_display();
        periph_pkg::word_t rd;
        periph_pkg::word_t data;
        for (int d = 0; d < periph_pkg::NUM_DIGITS; d++) begin
            for (int v = 0; v < 16; v++) begin
                // rotated order so each digit ends on a different value
                exp_digit[d]   = periph_pkg::hex_digit_t'(v + d * 5);
                exp_written[d] = 1'b1;
                data = (next_rand() & 32'hFFFF_FFF0) | periph_pkg::word_t'(exp_digit[d]);
                ahb_write(digit_addr(d), data);
                @(negedge clk);
                check_display($sformatf("digit %0d value %0h", d, exp_digit[d]));
            end
        end
        for (int d = 0; d < periph_pkg::NUM_DIGITS; d++) begin
            ahb_read(digit_addr(d), rd);
            check_word(rd, periph_pkg::word_t'(exp_digit[d]), $sformatf("digit %0d read", d));
        end
    endtask

    task automatic test_forwarding();
        periph_pkg::word_t      rd;
        periph_pkg::word_t      data;
        periph_pkg::hex_digit_t nv;
        nv   = ~exp_digit[3];    // differs from the stored value
        data = (next_rand() & 32'hFFFF_FFF0) | periph_pkg::word_t'(nv);
        write_then_read(digit_addr(3), data, rd);
        exp_digit[3] = nv;
        check_word(rd, periph_pkg::word_t'(nv), "digit 3 write then read");
        data = next_rand();
        write_then_read(periph_pkg::GPIO_BASE + periph_pkg::word_t'(periph_pkg::GPIO_LED_OFS),
                        data, rd);
        exp_led = periph_pkg::led_t'(data);
        check_word(rd, periph_pkg::word_t'(exp_led), "led write then read");
        @(negedge clk);
        check_display("after forwarding");
        check_led(led, exp_led, "led after forwarding");
    endtask

    task automatic test_gpio();
        periph_pkg::word_t rd;
        periph_pkg::word_t data;
        periph_pkg::sw_t   sw_val;
        data = next_rand();
        ahb_write(periph_pkg::GPIO_BASE + periph_pkg::word_t'(periph_pkg::GPIO_LED_OFS), data);
        exp_led = periph_pkg::led_t'(data);
        @(negedge clk);
        check_led(led, exp_led, "led after write");
        ahb_read(periph_pkg::GPIO_BASE + periph_pkg::word_t'(periph_pkg::GPIO_LED_OFS), rd);
        check_word(rd, periph_pkg::word_t'(exp_led), "led read back");
        for (int k = 0; k < 4; k++) begin
            sw_val = periph_pkg::sw_t'(next_rand());
            sw     = sw_val;
            repeat (2) @(negedge clk);    // third cycle is the read's own negedge
            ahb_read(periph_pkg::GPIO_BASE + periph_pkg::word_t'(periph_pkg::GPIO_SW_OFS), rd);
            check_word(rd, periph_pkg::word_t'(sw_val), $sformatf("switch read %0d", k));
        end
    endtask

    task automatic error_case(input periph_pkg::word_t addr, input logic write,
                              input string what);
        periph_pkg::word_t rd;
        ahb_expect_error(addr, write, next_rand(), what);
        ahb_read(digit_addr(0), rd);    // bus has to recover
        check_word(rd, periph_pkg::word_t'(exp_digit[0]), {what, " recovery read"});
        check_display(what);
        check_led(led, exp_led, {what, " led"});
    endtask

    task automatic test_errors();
        error_case(32'h5000_0000, 1'b1, "unmapped region write");
        error_case(32'h4000_2000, 1'b0, "unmapped region read");
        error_case(periph_pkg::DTUBE_BASE + 32'h18, 1'b1, "dtube offset 0x18 write");
        error_case(periph_pkg::DTUBE_BASE + 32'h100, 1'b0, "dtube offset 0x100 read");
        error_case(periph_pkg::GPIO_BASE + 32'h8, 1'b1, "gpio offset 0x8 write");
        error_case(periph_pkg::GPIO_BASE + periph_pkg::word_t'(periph_pkg::GPIO_SW_OFS), 1'b1,
                   "switch register write");
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        lcg_state = 32'd52428;
        rst_n     = 1'b0;
        haddr     = '0;
        htrans    = periph_pkg::HTRANS_IDLE;
        hwrite    = 1'b0;
        hsize     = 3'b010;
        hwdata    = '0;
        sw        = '0;
        exp_led   = '0;
        for (int i = 0; i < periph_pkg::NUM_DIGITS; i++) begin
            exp_digit[i]   = '0;
            exp_written[i] = 1'b0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset();
        test_display();
        test_forwarding();
        test_gpio();
        test_errors();

        @(negedge clk);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
periph_pkg.sv
ahb_periph_mux.sv
dtube_ctrl.sv
gpio_ctrl.sv
periph_top.sv
tb_periph_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --top-module tb_periph_top --Mdir obj_dir -f tb.f

./obj_dir/Vtb_periph_top | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

echo "simulation finished without failures"
